//--- smc_pkg.sv
// Static memory controller shared widths, AHB encodings and timing register layout
package smc_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int addr_w = 32;  // AHB and external address
  localparam int data_w = 32;  // AHB, APB and external data
  localparam int be_w   = 4;   // Byte lanes per word

  // AHB transfer size, only up to word supported
  typedef enum logic [2:0] {
    hsize_byte = 3'b000,
    hsize_half = 3'b001,
    hsize_word = 3'b010
  } hsize_e;

  // AHB response codes
  localparam logic [1:0] hresp_okay  = 2'b00;
  localparam logic [1:0] hresp_error = 2'b01;

  // --------------------------------------------------------------------------
  // Timing register
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [3:0] reserved;    // Reads back zero
    logic [3:0] turnaround;  // Idle cycles after each access
    logic [3:0] wr_wait;     // Extra write strobe cycles
    logic [3:0] rd_wait;     // Extra read strobe cycles
  } smc_timing_t;

  // One APB word, seen raw by the register block and as fields by the engine
  typedef union packed {
    logic [data_w-1:0] raw;
    struct packed {
      logic [15:0] spare;    // Upper half unused
      smc_timing_t tm;
    } fields;
  } smc_timing_u;

  // rd_wait 2, wr_wait 1, turnaround 1
  localparam logic [data_w-1:0] timing_reset = 32'h0000_0112;

  // Writable bits of the timing word
  localparam logic [data_w-1:0] timing_mask = 32'h0000_0fff;

endpackage

//--- smc_req_if.sv
// One-deep request channel from the AHB front end to the external bus engine
interface smc_req_if
  import smc_pkg::*;
();

  // Front end to engine
  logic              req;    // High with stable fields until done
  logic [addr_w-1:0] addr;   // Byte address
  logic              write;  // 1 = write, 0 = read
  logic [be_w-1:0]   n_be;   // Byte lanes, active low
  logic [data_w-1:0] wdata;  // Write data, lane aligned

  // Engine to front end
  logic              done;   // Single-cycle completion
  logic [data_w-1:0] rdata;  // Valid in the done cycle

  modport front (
    output req, addr, write, n_be, wdata,
    input  done, rdata
  );

  modport engine (
    input  req, addr, write, n_be, wdata,
    output done, rdata
  );

endinterface

//--- smc_ahb_slave.sv
// AHB-lite front end that checks transfers, builds byte lanes and stalls on hready
module smc_ahb_slave
  import smc_pkg::*;
#(
  parameter logic [addr_w-1:0] mem_base = 32'h0000_0000,
  parameter logic [addr_w-1:0] mem_size = 32'h0001_0000
) (
  input  logic              hclk,
  input  logic              arst_n,
  input  logic [addr_w-1:0] haddr,
  input  logic [1:0]        htrans,
  input  logic              hsel,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  logic [data_w-1:0] hwdata,
  input  logic              hready,
  output logic [data_w-1:0] smc_hrdata,
  output logic              smc_hready,
  output logic [1:0]        smc_hresp,
  output logic              smc_valid,
  smc_req_if.front          req
);

  typedef enum logic [2:0] {s_idle, s_data, s_wait, s_err1, s_err2} state_e;

  state_e            state;
  hsize_e            size;
  logic              accept;     // Address phase taken this cycle
  logic              in_window;
  logic              aligned;
  logic [be_w-1:0]   n_be_addr;  // Lanes for the current address phase
  logic [addr_w-1:0] addr_q;
  logic              write_q;
  logic [be_w-1:0]   n_be_q;
  logic [data_w-1:0] wdata_q;

  // --------------------------------------------------------------------------
  // Address phase decode
  // --------------------------------------------------------------------------
  assign size      = hsize_e'(hsize);
  assign accept    = hsel && hready && (htrans == 2'b10) && smc_hready;
  assign in_window = (haddr >= mem_base) && ((haddr - mem_base) < mem_size);

  always_comb begin
    aligned   = 1'b0;
    n_be_addr = '1;
    case (size)
      hsize_byte: begin
        aligned   = 1'b1;
        n_be_addr = ~(4'b0001 << haddr[1:0]);  // One lane
      end
      hsize_half: begin
        aligned   = ~haddr[0];
        n_be_addr = haddr[1] ? 4'b0011 : 4'b1100;  // Upper or lower half
      end
      hsize_word: begin
        aligned   = (haddr[1:0] == 2'b00);
        n_be_addr = 4'b0000;
      end
      default: aligned = 1'b0;  // Wider than the bus
    endcase
  end

  // --------------------------------------------------------------------------
  // Transfer FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= s_idle;
    end else begin
      case (state)
        s_data:  state <= s_wait;                      // hwdata taken, raise req
        s_wait:  if (req.done) state <= s_idle;
        s_err1:  state <= s_err2;                      // Second error cycle
        default: begin                                 // Idle or last error cycle
          if (accept) state <= (in_window && aligned) ? s_data : s_err1;
          else        state <= s_idle;
        end
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q  <= haddr;
      write_q <= hwrite;
      n_be_q  <= n_be_addr;
    end
    if (state == s_data) wdata_q <= hwdata;                       // Data phase
    if (state == s_wait && req.done && !write_q) smc_hrdata <= req.rdata;
  end

  assign smc_hready = !(state inside {s_data, s_wait, s_err1});
  assign smc_hresp  = (state inside {s_err1, s_err2}) ? hresp_error : hresp_okay;
  assign smc_valid  = (state == s_data);  // One pulse per legal transfer

  assign req.req   = (state == s_wait);
  assign req.addr  = addr_q;
  assign req.write = write_q;
  assign req.n_be  = n_be_q;
  assign req.wdata = wdata_q;

  // No new request overlaps the one just completed
  a_req_drop: assert property (@(posedge hclk) disable iff (!arst_n)
    req.done |=> !req.req);

endmodule

//--- smc_config_regs.sv
// APB register block with the access timing word and the engine status
module smc_config_regs
  import smc_pkg::*;
(
  input  logic              hclk,
  input  logic              arst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [4:0]        paddr,
  input  logic [31:0]       pwdata,
  input  logic              busy,     // From the engine
  output logic [31:0]       prdata,
  output smc_timing_u       timing    // To the engine
);

  // Register offsets
  localparam logic [4:0] off_timing = 5'h00;
  localparam logic [4:0] off_status = 5'h04;

  logic wr_en;  // Access phase write

  // --------------------------------------------------------------------------
  // Write side
  // --------------------------------------------------------------------------
  assign wr_en = psel && penable && pwrite;

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      timing.raw <= timing_reset;
    end else if (wr_en && (paddr == off_timing)) begin
      timing.raw <= pwdata & timing_mask;  // Reserved bits stay zero
    end
  end

  // --------------------------------------------------------------------------
  // Read side
  // --------------------------------------------------------------------------
  // Combinational, valid through the access phase
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        off_timing: prdata = timing.raw;
        off_status: prdata = {31'b0, busy};  // Busy in bit 0
        default:    prdata = '0;             // Unmapped
      endcase
    end
  end

  // APB enable only inside a selected transfer
  a_penable_psel: assert property (@(posedge hclk) disable iff (!arst_n)
    penable |-> psel);

endmodule

//--- smc_emi_engine.sv
// External bus sequencer driving chip select, lanes and strobes with wait states
module smc_emi_engine
  import smc_pkg::*;
(
  input  logic              hclk,
  input  logic              arst_n,
  input  smc_timing_u       timing,
  input  logic [data_w-1:0] data_smc,      // Read data from memory
  smc_req_if.engine         req,
  output logic [addr_w-1:0] smc_addr,
  output logic [data_w-1:0] smc_data,
  output logic [be_w-1:0]   smc_n_be,
  output logic              smc_n_cs,
  output logic [be_w-1:0]   smc_n_we,      // Per-lane write strobes
  output logic              smc_n_wr,
  output logic              smc_n_rd,
  output logic              smc_n_ext_oe,  // Data bus drive enable
  output logic              busy
);

  typedef enum logic [2:0] {s_idle, s_setup, s_strobe, s_hold, s_turn} state_e;

  state_e            state;
  smc_timing_t       tm_q;     // Timing latched at access start
  logic [3:0]        cnt;      // Remaining wait cycles
  logic              done_q;
  logic              write_q;
  logic [addr_w-1:0] addr_q;
  logic [be_w-1:0]   n_be_q;
  logic [data_w-1:0] wdata_q;
  logic [data_w-1:0] rdata_q;
  logic              start;
  logic              active;   // Chip select phase

  assign start = req.req && !done_q;  // Skip the cycle req is still high after done

  // --------------------------------------------------------------------------
  // Sequencer
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= s_idle;
      cnt    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        s_idle: if (start) state <= s_setup;
        s_setup: begin
          cnt   <= write_q ? tm_q.wr_wait : tm_q.rd_wait;
          state <= s_strobe;
        end
        s_strobe: begin
          if (cnt != 0) begin
            cnt <= cnt - 1'b1;
          end else if (write_q) begin
            state <= s_hold;
          end else if (tm_q.turnaround != 0) begin
            cnt   <= tm_q.turnaround - 1'b1;
            state <= s_turn;
          end else begin
            state  <= s_idle;  // Read without gap
            done_q <= 1'b1;
          end
        end
        s_hold: begin
          if (tm_q.turnaround != 0) begin
            cnt   <= tm_q.turnaround - 1'b1;
            state <= s_turn;
          end else begin
            state  <= s_idle;
            done_q <= 1'b1;
          end
        end
        s_turn: begin
          if (cnt != 0) begin
            cnt <= cnt - 1'b1;
          end else begin
            state  <= s_idle;
            done_q <= 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // Access payload and timing snapshot
  always_ff @(posedge hclk) begin
    if (state == s_idle && start) begin
      tm_q    <= timing.fields.tm;  // Later APB writes wait for the next access
      write_q <= req.write;
      addr_q  <= req.addr;
      n_be_q  <= req.n_be;
      wdata_q <= req.wdata;
    end
    if (state == s_strobe && cnt == 0 && !write_q) rdata_q <= data_smc;  // Last strobe cycle
  end

  // --------------------------------------------------------------------------
  // External bus drive
  // --------------------------------------------------------------------------
  assign active       = state inside {s_setup, s_strobe, s_hold};
  assign smc_addr     = addr_q;
  assign smc_data     = wdata_q;
  assign smc_n_cs     = !active;
  assign smc_n_be     = active ? n_be_q : '1;
  assign smc_n_wr     = !(state == s_strobe && write_q);
  assign smc_n_we     = (state == s_strobe && write_q) ? n_be_q : '1;
  assign smc_n_rd     = !(state == s_strobe && !write_q);
  assign smc_n_ext_oe = !(active && write_q);  // Drive through setup and hold
  assign busy         = (state != s_idle);

  assign req.done  = done_q;
  assign req.rdata = rdata_q;

  // Data bus driven only for a pending write request
  a_oe_write: assert property (@(posedge hclk) disable iff (!arst_n)
    !smc_n_ext_oe |-> req.req && req.write);

endmodule

//--- smc_veneer.sv
// Static memory controller top joining AHB front end, APB registers and bus engine
module smc_veneer
  import smc_pkg::*;
#(
  parameter logic [addr_w-1:0] mem_base = 32'h0000_0000,  // Accepted window
  parameter logic [addr_w-1:0] mem_size = 32'h0001_0000
) (
  input  logic              hclk,          // AHB and APB clock
  input  logic              arst_n,
  // APB
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [4:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  // AHB-lite
  input  logic [addr_w-1:0] haddr,
  input  logic [1:0]        htrans,
  input  logic              hsel,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  logic [data_w-1:0] hwdata,
  input  logic              hready,        // Muxed bus ready
  output logic [data_w-1:0] smc_hrdata,
  output logic              smc_hready,
  output logic [1:0]        smc_hresp,
  output logic              smc_valid,
  // External memory
  input  logic [data_w-1:0] data_smc,
  output logic [addr_w-1:0] smc_addr,
  output logic [data_w-1:0] smc_data,
  output logic [be_w-1:0]   smc_n_be,
  output logic              smc_n_cs,
  output logic [be_w-1:0]   smc_n_we,
  output logic              smc_n_wr,
  output logic              smc_n_rd,
  output logic              smc_n_ext_oe,
  output logic              smc_busy
);

  smc_timing_u timing;  // Register block to engine
  logic        busy;

  smc_req_if req_if ();

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------
  smc_ahb_slave #(.mem_base(mem_base), .mem_size(mem_size)) ahb_slave_i (
    .hclk, .arst_n, .haddr, .htrans, .hsel, .hwrite, .hsize, .hwdata, .hready,
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid,
    .req (req_if.front)
  );

  smc_config_regs config_regs_i (
    .hclk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .busy, .prdata, .timing
  );

  smc_emi_engine emi_engine_i (
    .hclk, .arst_n, .timing, .data_smc,
    .req (req_if.engine),
    .smc_addr, .smc_data, .smc_n_be, .smc_n_cs, .smc_n_we, .smc_n_wr, .smc_n_rd,
    .smc_n_ext_oe, .busy
  );

  assign smc_busy = busy;  // Status mirror

endmodule

//--- tb_clock_gen.sv
// Testbench clock source with a power-on reset pulse
module tb_clock_gen #(
  parameter int period       = 100,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;                        // Asserted from time zero
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;                        // Release away from the active edge
  end

endmodule

//--- tb_smc_checker.sv
// Testbench monitor for AHB responses, byte lanes and external strobe widths
module tb_smc_checker (
  input logic        clk,
  input logic        arst_n,
  input logic [31:0] exp_timing,  // Timing word last programmed
  input logic [3:0]  exp_n_be,    // Lane rule for the transfer in flight
  input logic [31:0] exp_rdata,
  input logic [1:0]  exp_resp,
  input logic        exp_rd,      // Read data is compared
  input logic        no_cs,       // Transfer must not reach the bus
  input logic [31:0] smc_hrdata,
  input logic        smc_hready,
  input logic [1:0]  smc_hresp,
  input logic        smc_valid,
  input logic        smc_n_cs,
  input logic [3:0]  smc_n_be,
  input logic [3:0]  smc_n_we,
  input logic        smc_n_wr,
  input logic        smc_n_rd
);

  string test_name  = "reset";
  int    mismatches = 0;
  int    failures   = 0;
  int    rd_low;               // Consecutive read strobe cycles
  int    wr_low;               // Consecutive write strobe cycles
  int    valid_cnt;            // Accept pulses in this transfer
  logic  in_xfer;              // AHB data phase stalled

  task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      mismatches++;
      $display("Mismatch in %s (%s): expected %h, actual %h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(string msg);
    failures++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  // --------------------------------------------------------------------------
  // Bus watch, sampled between clock edges
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (arst_n !== 1'b1) begin
      rd_low    = 0;
      wr_low    = 0;
      valid_cnt = 0;
      in_xfer   = 1'b0;
    end else begin
      if (!smc_n_cs && no_cs) report_failure("chip select went low for a rejected transfer");
      if (!smc_n_cs) compare("byte enables", exp_n_be, smc_n_be);
      if (!smc_n_wr) compare("write strobes", exp_n_be, smc_n_we);
      // Strobe widths, checked when the strobe returns high
      if (!smc_n_rd) begin
        rd_low++;
      end else if (rd_low != 0) begin
        compare("read strobe cycles", exp_timing[3:0] + 1, rd_low);
        rd_low = 0;
      end
      if (!smc_n_wr) begin
        wr_low++;
      end else if (wr_low != 0) begin
        compare("write strobe cycles", exp_timing[7:4] + 1, wr_low);
        wr_low = 0;
      end
      if (smc_valid === 1'b1) valid_cnt++;  // Legal address taken
      // End of a stalled data phase
      if (!smc_hready) begin
        in_xfer = 1'b1;
      end else if (in_xfer) begin
        in_xfer = 1'b0;
        compare("response", exp_resp, smc_hresp);
        compare("valid pulses", (exp_resp == 2'b00) ? 1 : 0, valid_cnt);
        valid_cnt = 0;
        if (exp_rd) compare("read data", exp_rdata, smc_hrdata);
      end
    end
  end

endmodule

//--- tb_smc.sv
// Testbench top for the static memory controller with SRAM model and shadow reference
module tb_smc;

  localparam int          mem_bytes    = 65536;                      // Default window
  localparam logic [31:0] reset_timing = {20'h0, 4'd1, 4'd1, 4'd2};  // ta 1, wr 1, rd 2
  localparam logic [1:0]  okay         = 2'b00;
  localparam logic [1:0]  error        = 2'b01;
  localparam logic [2:0]  sz_word      = 3'b010;
  localparam int          xfer_limit   = 200;  // Cycles per data phase

  logic        clk;
  logic        arst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hsel;
  logic        hwrite;
  logic [2:0]  hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  logic [1:0]  smc_hresp;
  logic        smc_valid;
  logic [31:0] data_smc;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic [3:0]  smc_n_we;
  logic        smc_n_wr;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;
  // Expectations handed to the checker
  logic [31:0] exp_timing;
  logic [3:0]  exp_n_be;
  logic [31:0] exp_rdata;
  logic [1:0]  exp_resp;
  logic        exp_rd;
  logic        no_cs;
  logic [7:0]  mem    [mem_bytes];  // SRAM contents
  logic [7:0]  shadow [mem_bytes];  // Reference copy
  logic [31:0] lcg_state;

  assign hready = smc_hready;  // Single slave, so the bus ready is ours

  tb_clock_gen #(.period(100), .reset_cycles(5)) clock_gen_i (.clk, .arst_n);

  smc_veneer smc_veneer_i (
    .hclk (clk), .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .haddr, .htrans, .hsel, .hwrite, .hsize, .hwdata, .hready,
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid, .data_smc, .smc_addr,
    .smc_data, .smc_n_be, .smc_n_cs, .smc_n_we, .smc_n_wr, .smc_n_rd,
    .smc_n_ext_oe, .smc_busy
  );

  tb_smc_checker checker_i (
    .clk, .arst_n, .exp_timing, .exp_n_be, .exp_rdata, .exp_resp, .exp_rd, .no_cs,
    .smc_hrdata, .smc_hready, .smc_hresp, .smc_valid, .smc_n_cs, .smc_n_be, .smc_n_we,
    .smc_n_wr, .smc_n_rd
  );

  // --------------------------------------------------------------------------
  // SRAM model
  // --------------------------------------------------------------------------
  assign data_smc = smc_n_rd ? 32'h0 :
                    {mem[{smc_addr[15:2], 2'd3}], mem[{smc_addr[15:2], 2'd2}],
                     mem[{smc_addr[15:2], 2'd1}], mem[{smc_addr[15:2], 2'd0}]};

  always @(posedge smc_n_wr) begin
    if (arst_n === 1'b1 && smc_n_cs === 1'b0) begin
      for (int b = 0; b < 4; b++)
        if (!smc_n_be[b]) mem[{smc_addr[15:2], b[1:0]}] = smc_data[8*b +: 8];
    end
  end

  // --------------------------------------------------------------------------
  // Reference model and random source
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Active-low lanes covered by 2**size bytes starting at the low address bits
  function automatic logic [3:0] lane_rule(logic [2:0] size, logic [31:0] addr);
    int         first;
    int         count;
    logic [3:0] n_be;
    first = addr[1:0];
    count = 1 << size;
    n_be  = 4'hf;
    for (int b = 0; b < 4; b++)
      if (b >= first && b < first + count) n_be[b] = 1'b0;
    return n_be;
  endfunction

  function automatic void shadow_write(logic [31:0] addr, logic [2:0] size, logic [31:0] data);
    logic [3:0] n_be;
    n_be = lane_rule(size, addr);
    for (int b = 0; b < 4; b++)
      if (!n_be[b]) shadow[{addr[15:2], b[1:0]}] = data[8*b +: 8];  // Merge lane
  endfunction

  function automatic logic [31:0] expected_read(logic [31:0] addr);
    return {shadow[{addr[15:2], 2'd3}], shadow[{addr[15:2], 2'd2}],
            shadow[{addr[15:2], 2'd1}], shadow[{addr[15:2], 2'd0}]};
  endfunction

  // --------------------------------------------------------------------------
  // Bus tasks, driven on the falling edge
  // --------------------------------------------------------------------------
  task automatic apb_write(logic [4:0] addr, logic [31:0] data);
    @(negedge clk);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;  // Write lands on the next rising edge
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(logic [4:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = addr;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;  // Access phase
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One nonsequential transfer, back once the data phase completes
  task automatic ahb_xfer(logic [31:0] addr, logic [2:0] size, logic write,
                          logic [31:0] data, logic [1:0] resp);
    int wait_cnt;
    @(negedge clk);
    haddr     = addr;
    hsize     = size;
    hwrite    = write;
    htrans    = 2'b10;
    hsel      = 1'b1;
    exp_resp  <= resp;
    exp_rd    <= !write && (resp == okay);
    exp_rdata <= expected_read(addr);
    exp_n_be  <= lane_rule(size, addr);
    no_cs     <= (resp != okay);
    @(negedge clk);
    htrans   = 2'b00;
    hsel     = 1'b0;
    hwdata   = data;  // Data phase
    wait_cnt = 0;
    while (smc_hready !== 1'b1 && wait_cnt < xfer_limit) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (smc_hready !== 1'b1) checker_i.report_failure("AHB transfer never completed");
    if (write && resp == okay) shadow_write(addr, size, data);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] addr;
    logic [31:0] data;
    logic [2:0]  size;
    logic [31:0] addrs [6];
    int          wait_cnt;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {haddr, htrans, hsel, hwrite, hsize, hwdata} = '0;
    {exp_n_be, exp_rdata, exp_resp, exp_rd, no_cs} = '0;
    exp_timing = reset_timing;
    lcg_state  = 32'h7c19;
    for (int i = 0; i < mem_bytes; i++) begin
      mem[i]    = i[7:0] ^ i[15:8] ^ 8'h5a;  // Differs across the whole address
      shadow[i] = i[7:0] ^ i[15:8] ^ 8'h5a;
    end

    wait_cnt = 0;
    while (arst_n !== 1'b1 && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (arst_n !== 1'b1) checker_i.report_failure("reset was never released");

    @(negedge clk);
    checker_i.test_name = "reset state";
    checker_i.compare("hready", 1, smc_hready);
    checker_i.compare("busy", 0, smc_busy);
    checker_i.compare("strobes", 32'hfff, {smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe,
                                           smc_n_we, smc_n_be});
    apb_read(5'h00, rd);
    checker_i.compare("timing", reset_timing, rd);

    checker_i.test_name = "register access";
    data = lcg_next() >> 8;
    apb_write(5'h00, data);
    apb_read(5'h00, rd);
    checker_i.compare("timing", data & 32'h0000_0fff, rd);  // Reserved bits read zero
    exp_timing <= data & 32'h0000_0fff;
    apb_read(5'h04, rd);
    checker_i.compare("status", 0, rd);

    // First timing setting, random
    checker_i.test_name = "word access";
    for (int n = 0; n < 6; n++) begin
      addrs[n] = lcg_next() & 32'h0000_fffc;
      ahb_xfer(addrs[n], sz_word, 1'b1, lcg_next(), okay);
    end
    for (int n = 0; n < 6; n++) ahb_xfer(addrs[n], sz_word, 1'b0, 32'h0, okay);

    // Second timing setting, rd 5, wr 3, no turnaround
    checker_i.test_name = "sized writes";
    apb_write(5'h00, 32'h0000_0035);
    exp_timing <= 32'h0000_0035;
    for (int n = 0; n < 8; n++) begin
      addr = lcg_next() & 32'h0000_ffff;
      data = lcg_next();
      size = data[20] ? 3'b001 : 3'b000;
      if (size == 3'b001) addr[0] = 1'b0;
      ahb_xfer(addr, size, 1'b1, data, okay);
      ahb_xfer(addr & 32'hffff_fffc, sz_word, 1'b0, 32'h0, okay);
    end

    checker_i.test_name = "error response";
    ahb_xfer(32'h0000_0101, 3'b001, 1'b0, 32'h0, error);    // Unaligned halfword
    ahb_xfer(32'h0002_0000, sz_word, 1'b1, lcg_next(), error);  // Outside the window
    ahb_xfer(32'h0000_0200, sz_word, 1'b0, 32'h0, okay);     // Bus still usable

    @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures",
             checker_i.mismatches, checker_i.failures);
    if (checker_i.mismatches + checker_i.failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
smc_pkg.sv
smc_req_if.sv
smc_ahb_slave.sv
smc_config_regs.sv
smc_emi_engine.sv
smc_veneer.sv
tb_clock_gen.sv
tb_smc_checker.sv
tb_smc.sv

//--- Bender.yml
package:
  name: smc

sources:
  - smc_pkg.sv
  - smc_req_if.sv
  - smc_ahb_slave.sv
  - smc_config_regs.sv
  - smc_emi_engine.sv
  - smc_veneer.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_smc_checker.sv
      - tb_smc.sv
